// File: include/dma_defs.svh
/* DMA engine build constants
   for widths, burst limit and FIFO depths */
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// one data beat on both AXI sides
`define DMA_DATA_W      64
`define DMA_ADDR_W      32

// descriptor length, counted in beats
`define DMA_LENGTH_W    10

// kept small so that transfers split into several bursts
`define DMA_MAX_BURST   4

`define DMA_DESC_DEPTH  4
`define DMA_DATA_DEPTH  8

`endif

// File: rtl/dma_pkg.sv
/* DMA package
   with descriptor, AXI channel and status types */
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

   localparam int BEAT_BYTES = `DMA_DATA_W / 8;
   localparam logic [2:0] AXI_SIZE = 3'($clog2(BEAT_BYTES));
   localparam logic [1:0] BURST_INCR = 2'b01;
   localparam logic [`DMA_LENGTH_W-1:0] MAX_BURST_BEATS = `DMA_MAX_BURST;

   typedef logic [`DMA_DATA_W-1:0] t_dma_word;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0]   src_addr;
      logic [`DMA_ADDR_W-1:0]   dest_addr;
      logic [`DMA_LENGTH_W-1:0] length;
   } t_dma_descriptor;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } t_axi_resp;

   // len is beats minus one
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
      logic [1:0]             burst;
   } t_axi_aw;

   typedef t_axi_aw t_axi_ar;

   typedef struct packed {
      t_dma_word                 data;
      logic [`DMA_DATA_W/8-1:0]  strb;
      logic                      last;
   } t_axi_w;

   typedef struct packed {
      t_dma_word data;
      t_axi_resp resp;
      logic      last;
   } t_axi_r;

   typedef struct packed {
      logic        busy;
      logic        stopped_on_error;
      logic [15:0] done_count;
   } t_dma_status;

endpackage

`default_nettype wire

// File: rtl/dma_fifo.sv
/* dma_fifo: synchronous FIFO for any payload type
   with the head entry shown on rd_data without read latency */
`timescale 1ns/1ns
`default_nettype none

module dma_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
)(
   input  wire logic clk,
   input  wire logic reset_n,
   input  wire logic wr_en,
   input  wire T     wr_data,
   input  wire logic rd_en,
   output T          rd_data,
   output logic      not_empty,
   output logic      not_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
   localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             push;
   logic             pop;

   assign push      = wr_en && not_full;
   assign pop       = rd_en && not_empty;
   assign not_empty = (count != '0);
   assign not_full  = (count != FULL_COUNT);
   assign rd_data   = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/read_src_fsm.sv
/* read_src_fsm: fetches the head descriptor's source data in INCR bursts
   and pushes every R beat into the data FIFO */
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module read_src_fsm (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   input  wire logic                     enable,
   input  wire logic                     desc_not_empty,
   input  wire dma_pkg::t_dma_descriptor desc,
   input  wire logic                     desc_retire,
   output logic                          arvalid,
   output dma_pkg::t_axi_ar              ar,
   input  wire logic                     arready,
   input  wire logic                     rvalid,
   input  wire dma_pkg::t_axi_r          r,
   output logic                          rready,
   output logic                          fifo_wr_en,
   output dma_pkg::t_dma_word            fifo_wr_data,
   input  wire logic                     fifo_not_full
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      HOLD
   } t_state;

   t_state                   state;
   logic [`DMA_ADDR_W-1:0]   rd_addr;
   logic [`DMA_LENGTH_W-1:0] beats_left;
   logic [`DMA_LENGTH_W-1:0] burst_beats;
   logic [`DMA_ADDR_W-1:0]   burst_step;
   logic                     ar_fire;
   logic                     r_fire;

   assign burst_beats = (beats_left > dma_pkg::MAX_BURST_BEATS) ?
                        dma_pkg::MAX_BURST_BEATS : beats_left;
   assign burst_step  = {{(`DMA_ADDR_W - `DMA_LENGTH_W){1'b0}}, burst_beats}
                        << dma_pkg::AXI_SIZE;

   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid && rready;

   // ar is built from registers, so it holds while arready is low
   assign arvalid  = (state == ADDR);
   assign ar.addr  = rd_addr;
   assign ar.len   = burst_beats[7:0] - 8'd1;
   assign ar.size  = dma_pkg::AXI_SIZE;
   assign ar.burst = dma_pkg::BURST_INCR;

   assign rready       = fifo_not_full;
   assign fifo_wr_en   = r_fire;
   assign fifo_wr_data = r.data;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         unique case (state)
            IDLE: if (enable && desc_not_empty) begin
               state <= ADDR;
            end
            ADDR: if (ar_fire) begin
               state <= DATA;
            end
            DATA: if (r_fire && r.last) begin
               state <= (beats_left == '0) ? HOLD : ADDR;
            end
            // the head stays put until the write side retires it
            HOLD: if (desc_retire) begin
               state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         rd_addr    <= desc.src_addr;
         beats_left <= desc.length;
      end else if (ar_fire) begin
         rd_addr    <= rd_addr + burst_step;
         beats_left <= beats_left - burst_beats;
      end
   end

endmodule

`default_nettype wire

// File: rtl/write_dest_fsm.sv
/* write_dest_fsm: drains the data FIFO to the destination in INCR bursts,
   one AW outstanding at a time, and reports done or a sticky error */
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module write_dest_fsm (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   input  wire logic                     enable,
   input  wire logic                     clear_error,
   input  wire logic                     desc_not_empty,
   input  wire dma_pkg::t_dma_descriptor desc,
   output logic                          awvalid,
   output dma_pkg::t_axi_aw              aw,
   input  wire logic                     awready,
   output logic                          wvalid,
   output dma_pkg::t_axi_w               w,
   input  wire logic                     wready,
   input  wire logic                     bvalid,
   input  wire dma_pkg::t_axi_resp       b,
   output logic                          bready,
   output logic                          fifo_rd_en,
   input  wire dma_pkg::t_dma_word       fifo_rd_data,
   input  wire logic                     fifo_not_empty,
   output logic                          done,
   output logic                          desc_retire,
   output dma_pkg::t_dma_status          status
);

   typedef enum int {
      IDLE_BIT,
      ADDR_SETUP_BIT,
      FIFO_EMPTY_BIT,
      RD_FIFO_WR_DEST_BIT,
      WAIT_FOR_WR_RSP_BIT,
      ERROR_BIT
   } t_state_bit;

   typedef enum logic [5:0] {
      IDLE            = 6'b1 << IDLE_BIT,
      ADDR_SETUP      = 6'b1 << ADDR_SETUP_BIT,
      FIFO_EMPTY      = 6'b1 << FIFO_EMPTY_BIT,
      RD_FIFO_WR_DEST = 6'b1 << RD_FIFO_WR_DEST_BIT,
      WAIT_FOR_WR_RSP = 6'b1 << WAIT_FOR_WR_RSP_BIT,
      ERROR           = 6'b1 << ERROR_BIT
   } t_state;

   t_state                   state;
   t_state                   next;
   logic [`DMA_LENGTH_W-1:0] beats_left;
   logic [`DMA_LENGTH_W-1:0] beat_cnt;
   logic [`DMA_LENGTH_W-1:0] len_src;
   logic [`DMA_LENGTH_W-1:0] burst_beats;
   logic [`DMA_ADDR_W-1:0]   aw_step;
   logic [15:0]              done_count;
   logic                     err_seen;
   logic                     start_burst;
   logic                     w_fire;
   logic                     b_fire;
   logic                     resp_err;
   logic                     final_rsp;

   // first burst sizes from the descriptor, later ones from what is left
   assign len_src     = state[IDLE_BIT] ? desc.length : beats_left;
   assign burst_beats = (len_src > dma_pkg::MAX_BURST_BEATS) ?
                        dma_pkg::MAX_BURST_BEATS : len_src;
   assign aw_step     = ({{(`DMA_ADDR_W - 8){1'b0}}, aw.len} + 1'b1) << dma_pkg::AXI_SIZE;
   assign start_burst = next[ADDR_SETUP_BIT] && !state[ADDR_SETUP_BIT];

   assign wvalid     = state[RD_FIFO_WR_DEST_BIT] && fifo_not_empty;
   assign w_fire     = wvalid && wready;
   assign fifo_rd_en = w_fire;
   assign w.data     = fifo_rd_data;
   assign w.strb     = '1;
   assign w.last     = (beat_cnt == 'd1);

   assign bready    = 1'b1;
   assign b_fire    = state[WAIT_FOR_WR_RSP_BIT] && bvalid && bready;
   assign resp_err  = b_fire && (b != dma_pkg::OKAY);
   assign final_rsp = b_fire && (beats_left == '0);

   assign done        = final_rsp && !err_seen && !resp_err;
   assign desc_retire = done || (state[ERROR_BIT] && clear_error);

   assign status.busy             = !state[IDLE_BIT] && !state[ERROR_BIT];
   assign status.stopped_on_error = state[ERROR_BIT];
   assign status.done_count       = done_count;

   always_comb begin
      next = state;
      unique case (1'b1)
         state[IDLE_BIT]:
            if (enable && desc_not_empty) next = ADDR_SETUP;
         state[ADDR_SETUP_BIT]:
            if (awvalid && awready) next = fifo_not_empty ? RD_FIFO_WR_DEST : FIFO_EMPTY;
         state[FIFO_EMPTY_BIT]:
            if (fifo_not_empty) next = RD_FIFO_WR_DEST;
         state[RD_FIFO_WR_DEST_BIT]:
            if (w_fire && w.last) next = WAIT_FOR_WR_RSP;
            else if (!fifo_not_empty) next = FIFO_EMPTY;
         state[WAIT_FOR_WR_RSP_BIT]:
            if (b_fire && (beats_left != '0)) next = ADDR_SETUP;
            else if (final_rsp && (err_seen || resp_err)) next = ERROR;
            else if (final_rsp) next = IDLE;
         state[ERROR_BIT]:
            if (clear_error) next = IDLE;
         default: next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state      <= IDLE;
         awvalid    <= 1'b0;
         err_seen   <= 1'b0;
         done_count <= '0;
      end else begin
         state <= next;
         if (start_burst) begin
            awvalid <= 1'b1;
         end else if (awready) begin
            awvalid <= 1'b0;
         end
         // an SLVERR on any burst fails the whole descriptor
         if (state[IDLE_BIT]) begin
            err_seen <= 1'b0;
         end else if (resp_err) begin
            err_seen <= 1'b1;
         end
         if (done) begin
            done_count <= done_count + 16'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_burst) begin
         aw.addr    <= state[IDLE_BIT] ? desc.dest_addr : aw.addr + aw_step;
         aw.len     <= burst_beats[7:0] - 8'd1;
         aw.size    <= dma_pkg::AXI_SIZE;
         aw.burst   <= dma_pkg::BURST_INCR;
         beats_left <= len_src - burst_beats;
         beat_cnt   <= burst_beats;
      end else if (w_fire) begin
         beat_cnt <= beat_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/dma_engine.sv
/* dma_engine: memory-to-memory DMA top level
   with descriptor and data FIFOs between the read and write engines */
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_engine (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   input  wire logic                     desc_valid,
   input  wire dma_pkg::t_dma_descriptor desc,
   output logic                          desc_ready,
   output logic                          arvalid,
   output dma_pkg::t_axi_ar              ar,
   input  wire logic                     arready,
   input  wire logic                     rvalid,
   input  wire dma_pkg::t_axi_r          r,
   output logic                          rready,
   output logic                          awvalid,
   output dma_pkg::t_axi_aw              aw,
   input  wire logic                     awready,
   output logic                          wvalid,
   output dma_pkg::t_axi_w               w,
   input  wire logic                     wready,
   input  wire logic                     bvalid,
   input  wire dma_pkg::t_axi_resp       b,
   output logic                          bready,
   output dma_pkg::t_dma_status          status,
   output logic                          done,
   input  wire logic                     clear_error,
   input  wire logic                     enable
);

   dma_pkg::t_dma_descriptor desc_head;
   dma_pkg::t_dma_word       data_wr;
   dma_pkg::t_dma_word       data_rd;
   logic                     desc_not_empty;
   logic                     desc_retire;
   logic                     data_wr_en;
   logic                     data_rd_en;
   logic                     data_not_empty;
   logic                     data_not_full;

   dma_fifo #(
      .T     (dma_pkg::t_dma_descriptor),
      .DEPTH (`DMA_DESC_DEPTH)
   ) desc_fifo_i (
      .clk       (clk),
      .reset_n   (reset_n),
      .wr_en     (desc_valid),
      .wr_data   (desc),
      .rd_en     (desc_retire),
      .rd_data   (desc_head),
      .not_empty (desc_not_empty),
      .not_full  (desc_ready)
   );

   dma_fifo #(
      .T     (dma_pkg::t_dma_word),
      .DEPTH (`DMA_DATA_DEPTH)
   ) data_fifo_i (
      .clk       (clk),
      .reset_n   (reset_n),
      .wr_en     (data_wr_en),
      .wr_data   (data_wr),
      .rd_en     (data_rd_en),
      .rd_data   (data_rd),
      .not_empty (data_not_empty),
      .not_full  (data_not_full)
   );

   read_src_fsm read_src_fsm_i (
      .clk            (clk),
      .reset_n        (reset_n),
      .enable         (enable),
      .desc_not_empty (desc_not_empty),
      .desc           (desc_head),
      .desc_retire    (desc_retire),
      .arvalid        (arvalid),
      .ar             (ar),
      .arready        (arready),
      .rvalid         (rvalid),
      .r              (r),
      .rready         (rready),
      .fifo_wr_en     (data_wr_en),
      .fifo_wr_data   (data_wr),
      .fifo_not_full  (data_not_full)
   );

   write_dest_fsm write_dest_fsm_i (
      .clk            (clk),
      .reset_n        (reset_n),
      .enable         (enable),
      .clear_error    (clear_error),
      .desc_not_empty (desc_not_empty),
      .desc           (desc_head),
      .awvalid        (awvalid),
      .aw             (aw),
      .awready        (awready),
      .wvalid         (wvalid),
      .w              (w),
      .wready         (wready),
      .bvalid         (bvalid),
      .b              (b),
      .bready         (bready),
      .fifo_rd_en     (data_rd_en),
      .fifo_rd_data   (data_rd),
      .fifo_not_empty (data_not_empty),
      .done           (done),
      .desc_retire    (desc_retire),
      .status         (status)
   );

endmodule

`default_nettype wire

// File: tb/dma_engine_sva.sv
/* dma_engine_sva: assertions on the write engine's AXI outputs,
   bound into write_dest_fsm */
`timescale 1ns/1ns
`default_nettype none

module dma_engine_sva (
   input wire logic             clk,
   input wire logic             reset_n,
   input wire logic             awvalid,
   input wire dma_pkg::t_axi_aw aw,
   input wire logic             awready,
   input wire logic             wvalid,
   input wire dma_pkg::t_axi_w  w,
   input wire logic             wready,
   input wire logic             fifo_not_empty,
   input wire logic             done
);

   // a pending AW request may not change or drop before it is taken
   a_aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(aw))
      else $error("aw request changed or dropped before awready");

   // a stalled W beat keeps its data and its entry in the data FIFO
   a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
      wvalid && !wready |=> wvalid && fifo_not_empty && $stable(w))
      else $error("stalled W beat changed or lost its data FIFO entry");

   a_reset_quiet: assert property (@(posedge clk)
      !reset_n |=> !awvalid && !wvalid && !done)
      else $error("awvalid, wvalid or done high after reset");

endmodule

bind write_dest_fsm dma_engine_sva dma_engine_sva_i (
   .clk            (clk),
   .reset_n        (reset_n),
   .awvalid        (awvalid),
   .aw             (aw),
   .awready        (awready),
   .wvalid         (wvalid),
   .w              (w),
   .wready         (wready),
   .fifo_not_empty (fifo_not_empty),
   .done           (done)
);

`default_nettype wire

// File: tb/dma_engine_tb.sv
/* dma_engine testbench with an AXI memory model and a descriptor table,
   checking write bursts, data, done pulses and error recovery */
`timescale 1ns/1ns
`default_nettype none

`include "dma_defs.svh"

module dma_engine_tb;

   localparam int N_ROWS     = 7;
   localparam int BEAT_BYTES = `DMA_DATA_W / 8;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0]   src_addr;
      logic [`DMA_ADDR_W-1:0]   dest_addr;
      logic [`DMA_LENGTH_W-1:0] length;
      logic                     expect_error;
   } t_row;

   logic                     clk;
   logic                     reset_n;
   logic                     desc_valid;
   dma_pkg::t_dma_descriptor desc;
   logic                     desc_ready;
   logic                     arvalid;
   dma_pkg::t_axi_ar         ar;
   logic                     arready;
   logic                     rvalid;
   dma_pkg::t_axi_r          r;
   logic                     rready;
   logic                     awvalid;
   dma_pkg::t_axi_aw         aw;
   logic                     awready;
   logic                     wvalid;
   dma_pkg::t_axi_w          w;
   logic                     wready;
   logic                     bvalid;
   dma_pkg::t_axi_resp       b;
   logic                     bready;
   dma_pkg::t_dma_status     status;
   logic                     done;
   logic                     clear_error;
   logic                     enable;

   t_row                   rows [N_ROWS];
   dma_pkg::t_axi_ar       ar_exp_q [$];
   dma_pkg::t_axi_aw       aw_exp_q [$];
   dma_pkg::t_axi_w        w_exp_q [$];
   dma_pkg::t_axi_ar       ar_q [$];
   dma_pkg::t_axi_aw       wa_q [$];
   dma_pkg::t_axi_resp     b_q [$];
   dma_pkg::t_dma_word     mem [logic [`DMA_ADDR_W-1:0]];
   integer                 seed;
   int                     total_beats;
   int                     ok_count;
   int                     timeout_limit;
   int                     cycles;
   int                     row_idx;
   int                     done_seen;
   int                     w_idx;
   int                     r_left;
   logic [`DMA_ADDR_W-1:0] r_addr;
   logic                   ready_dropped;

   dma_engine dma_engine_i (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // source memory holds the address next to its inverse
   function automatic dma_pkg::t_dma_word source_word(input logic [`DMA_ADDR_W-1:0] addr);
      return {addr, ~addr};
   endfunction

   function automatic logic in_error_window(input logic [`DMA_ADDR_W-1:0] addr);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < N_ROWS; i++) begin
         if (rows[i].expect_error && addr >= rows[i].dest_addr &&
             addr < rows[i].dest_addr + BEAT_BYTES * rows[i].length) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("=== FAIL ===");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_ar(input dma_pkg::t_axi_ar got, input dma_pkg::t_axi_ar exp);
      if (got !== exp) begin
         stop_with_failure($sformatf(
            "mismatch at %0t: ar %h/%0d/%0d/%0d, expected %h/%0d/%0d/%0d",
            $time, got.addr, got.len, got.size, got.burst,
            exp.addr, exp.len, exp.size, exp.burst));
      end
   endtask

   task automatic check_aw(input dma_pkg::t_axi_aw got, input dma_pkg::t_axi_aw exp);
      if (got !== exp) begin
         stop_with_failure($sformatf(
            "mismatch at %0t: aw %h/%0d/%0d/%0d, expected %h/%0d/%0d/%0d",
            $time, got.addr, got.len, got.size, got.burst,
            exp.addr, exp.len, exp.size, exp.burst));
      end
   endtask

   task automatic check_beat(input dma_pkg::t_axi_w got, input dma_pkg::t_axi_w exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t: w %h strb %h last %b, expected %h last %b",
                                     $time, got.data, got.strb, got.last, exp.data, exp.last));
      end
   endtask

   task automatic check_status(input dma_pkg::t_dma_status got, input dma_pkg::t_dma_status exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t: status %b/%b/%0d, expected %b/%b/%0d",
                                     $time, got.busy, got.stopped_on_error, got.done_count,
                                     exp.busy, exp.stopped_on_error, exp.done_count));
      end
   endtask

   // expected read and write bursts of at most DMA_MAX_BURST beats each
   task automatic build_expected();
      dma_pkg::t_axi_aw a;
      dma_pkg::t_axi_ar ra;
      dma_pkg::t_axi_w  wb;
      int               off;
      int               n;
      for (int i = 0; i < N_ROWS; i++) begin
         off = 0;
         while (off < int'(rows[i].length)) begin
            n = int'(rows[i].length) - off;
            if (n > `DMA_MAX_BURST) n = `DMA_MAX_BURST;
            a.addr  = rows[i].dest_addr + BEAT_BYTES * off;
            a.len   = 8'(n - 1);
            a.size  = 3'($clog2(BEAT_BYTES));
            a.burst = 2'b01;
            aw_exp_q.push_back(a);
            ra      = a;
            ra.addr = rows[i].src_addr + BEAT_BYTES * off;
            ar_exp_q.push_back(ra);
            for (int k = 0; k < n; k++) begin
               wb.data = source_word(rows[i].src_addr + BEAT_BYTES * (off + k));
               wb.strb = '1;
               wb.last = (k == n - 1);
               w_exp_q.push_back(wb);
            end
            off += n;
         end
         total_beats += int'(rows[i].length);
         if (!rows[i].expect_error) ok_count++;
      end
   endtask

   // memory model samples handshakes mid-cycle and drives just after the edge
   always begin : memory_model
      logic r_fire;
      logic b_taken;
      @(negedge clk);
      r_fire  = rvalid && rready;
      b_taken = bvalid && bready;
      if (reset_n) begin
         if (arvalid && arready) begin
            if (ar_exp_q.size() == 0) begin
               stop_with_failure("a read burst was issued beyond the expected ones");
            end else begin
               check_ar(ar, ar_exp_q.pop_front());
               ar_q.push_back(ar);
            end
         end
         if (r_fire) begin
            r_addr += BEAT_BYTES;
            r_left--;
         end
         if (awvalid && awready) begin
            if (aw_exp_q.size() == 0) begin
               stop_with_failure("a write burst was issued beyond the expected ones");
            end else begin
               check_aw(aw, aw_exp_q.pop_front());
               wa_q.push_back(aw);
            end
         end
         if (wvalid && wready) begin
            if (w_exp_q.size() == 0 || wa_q.size() == 0) begin
               stop_with_failure("a write beat arrived with no write burst pending");
            end else begin
               check_beat(w, w_exp_q.pop_front());
               mem[wa_q[0].addr + BEAT_BYTES * w_idx] = w.data;
               w_idx++;
               if (w.last) begin
                  b_q.push_back(in_error_window(wa_q[0].addr) ? dma_pkg::SLVERR : dma_pkg::OKAY);
                  void'(wa_q.pop_front());
                  w_idx = 0;
               end
            end
         end
      end
      @(posedge clk);
      #1;
      arready = ($random(seed) & 3) != 0;
      awready = ($random(seed) & 3) != 0;
      wready  = ($random(seed) & 3) != 0;
      if (!bvalid || b_taken) begin
         bvalid = 1'b0;
         if (b_q.size() != 0 && ($random(seed) & 1) != 0) begin
            b      = b_q.pop_front();
            bvalid = 1'b1;
         end
      end
      if (!rvalid || r_fire) begin
         rvalid = 1'b0;
         if (r_left == 0 && ar_q.size() != 0) begin
            r_addr = ar_q[0].addr;
            r_left = int'(ar_q[0].len) + 1;
            void'(ar_q.pop_front());
         end
         if (r_left != 0 && ($random(seed) & 3) != 0) begin
            rvalid = 1'b1;
            r.data = source_word(r_addr);
            r.resp = dma_pkg::OKAY;
            r.last = (r_left == 1);
         end
      end
   end

   // follows the descriptors in table order and clears each error stop
   always begin : progress_monitor
      @(negedge clk);
      if (reset_n && done) begin
         if (row_idx >= N_ROWS || rows[row_idx].expect_error) begin
            stop_with_failure($sformatf("done pulsed for descriptor %0d that must fail", row_idx));
         end else begin
            check_status(status, dma_pkg::t_dma_status'{busy: 1'b1, stopped_on_error: 1'b0,
                                                        done_count: 16'(done_seen)});
            done_seen++;
            row_idx++;
         end
      end else if (reset_n && status.stopped_on_error) begin
         if (row_idx >= N_ROWS || !rows[row_idx].expect_error) begin
            stop_with_failure($sformatf("engine stopped on error at good descriptor %0d", row_idx));
         end else begin
            check_status(status, dma_pkg::t_dma_status'{busy: 1'b0, stopped_on_error: 1'b1,
                                                        done_count: 16'(done_seen)});
            @(posedge clk);
            #1;
            clear_error = 1'b1;
            @(posedge clk);
            #1;
            clear_error = 1'b0;
            row_idx++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > timeout_limit) begin
         stop_with_failure($sformatf("timeout: run not finished after %0d cycles", timeout_limit));
      end
   end

   initial begin : stimulus
      logic [`DMA_ADDR_W-1:0] addr;
      seed        = 32'hcf4;
      reset_n     = 1'b0;
      enable      = 1'b0;
      clear_error = 1'b0;
      desc_valid  = 1'b0;
      desc        = '0;
      arready     = 1'b0;
      rvalid      = 1'b0;
      r           = '0;
      awready     = 1'b0;
      wready      = 1'b0;
      bvalid      = 1'b0;
      b           = dma_pkg::OKAY;
      r_left      = 0;
      r_addr      = '0;
      w_idx       = 0;
      ready_dropped = 1'b0;
      // src_addr, dest_addr, length, expect_error
      rows[0] = '{32'h0000_1000, 32'h0000_8000, 10'd10, 1'b0};
      rows[1] = '{32'h0000_1100, 32'h0000_8100, 10'd3, 1'b0};
      rows[2] = '{32'h0000_1200, 32'h0000_8200, 10'd6, 1'b1};
      rows[3] = '{32'h0000_1300, 32'h0000_8300, 10'd4, 1'b0};
      rows[4] = '{32'h0000_1400, 32'h0000_8400, 10'd1, 1'b0};
      rows[5] = '{32'h0000_1500, 32'h0000_8500, 10'd8, 1'b0};
      rows[6] = '{32'h0000_1600, 32'h0000_8600, 10'd5, 1'b0};
      build_expected();
      timeout_limit = 50 * total_beats + 500;
      repeat (3) @(posedge clk);
      #1;
      reset_n = 1'b1;
      enable  = 1'b1;
      // pushed back to back so that the descriptor FIFO fills up
      for (int i = 0; i < N_ROWS; i++) begin
         desc_valid     = 1'b1;
         desc.src_addr  = rows[i].src_addr;
         desc.dest_addr = rows[i].dest_addr;
         desc.length    = rows[i].length;
         @(negedge clk);
         while (!desc_ready) begin
            ready_dropped = 1'b1;
            @(negedge clk);
         end
         @(posedge clk);
         #1;
      end
      desc_valid = 1'b0;
      wait (row_idx == N_ROWS);
      repeat (2) @(negedge clk);
      check_status(status, dma_pkg::t_dma_status'{busy: 1'b0, stopped_on_error: 1'b0,
                                                  done_count: 16'(ok_count)});
      for (int i = 0; i < N_ROWS; i++) begin
         for (int k = 0; k < int'(rows[i].length); k++) begin
            addr = rows[i].dest_addr + BEAT_BYTES * k;
            if (!mem.exists(addr)) begin
               stop_with_failure($sformatf("destination beat at %h was never written", addr));
            end else if (mem[addr] !== source_word(rows[i].src_addr + BEAT_BYTES * k)) begin
               stop_with_failure($sformatf("mismatch at %0t: dest %h holds %h, expected %h",
                                           $time, addr, mem[addr],
                                           source_word(rows[i].src_addr + BEAT_BYTES * k)));
            end
         end
      end
      if (mem.num() != total_beats || aw_exp_q.size() != 0 || w_exp_q.size() != 0 ||
          ar_exp_q.size() != 0) begin
         stop_with_failure("writes fell outside the descriptor ranges or bursts are missing");
      end else if (!ready_dropped) begin
         stop_with_failure("desc_ready never dropped while descriptors were pushed");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: dma_engine.f
+incdir+include
rtl/dma_pkg.sv
rtl/dma_fifo.sv
rtl/read_src_fsm.sv
rtl/write_dest_fsm.sv
rtl/dma_engine.sv
tb/dma_engine_sva.sv
tb/dma_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the DMA engine testbench with Verilator and runs it;
# the exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f dma_engine.f --top-module dma_engine_tb -Mdir obj_dir \
   && ./obj_dir/Vdma_engine_tb \
   && echo "simulation finished without errors" \
   || { echo "simulation failed"; exit 1; }
